/* common/cluster_bus_pkg.sv */
// Cluster egress bus definitions
`default_nettype none

package cluster_bus_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int AddrWidth      = 32;
  localparam int DataWidth      = 32;
  localparam int CoreIdWidth    = 4;
  localparam int PortIdxWidth   = 2;
  localparam int ClusterIdWidth = CoreIdWidth + PortIdxWidth;
  localparam int ExtIdWidth     = 2;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  typedef enum logic {
    RESP_OKAY = 1'b0,
    RESP_ERR  = 1'b1
  } bus_resp_e;

  // ----------------------------------------
  // Request channel, one beat per transaction
  // ----------------------------------------
  typedef struct packed {
    bus_op_e                op;
    logic [AddrWidth-1:0]   addr;
    logic [DataWidth-1:0]   wdata;
    logic [CoreIdWidth-1:0] id;
  } core_req_t;

  typedef struct packed {
    bus_op_e                   op;
    logic [AddrWidth-1:0]      addr;
    logic [DataWidth-1:0]      wdata;
    logic [ClusterIdWidth-1:0] id;
  } cl_req_t;

  typedef struct packed {
    bus_op_e               op;
    logic [AddrWidth-1:0]  addr;
    logic [DataWidth-1:0]  wdata;
    logic [ExtIdWidth-1:0] id;
  } ext_req_t;

  // ----------------------------------------
  // Response channel
  // ----------------------------------------
  typedef struct packed {
    bus_resp_e              resp;
    logic [DataWidth-1:0]   rdata;
    logic [CoreIdWidth-1:0] id;
  } core_rsp_t;

  typedef struct packed {
    bus_resp_e                 resp;
    logic [DataWidth-1:0]      rdata;
    logic [ClusterIdWidth-1:0] id;
  } cl_rsp_t;

  typedef struct packed {
    bus_resp_e             resp;
    logic [DataWidth-1:0]  rdata;
    logic [ExtIdWidth-1:0] id;
  } ext_rsp_t;

endpackage

`default_nettype wire

/* src/cluster_arbiter.sv */
// Round-robin requester arbiter
`timescale 1ns/100ps
`default_nettype none

module cluster_arbiter #(
  parameter int NUM_PORTS = 2
) (
  input  wire logic                                     clk_i,
  input  wire logic                                     arst_n_i,
  input  cluster_bus_pkg::core_req_t [NUM_PORTS-1:0]    core_req_i,
  input  wire logic [NUM_PORTS-1:0]                     core_req_valid_i,
  output logic [NUM_PORTS-1:0]                          core_req_ready_o,
  output cluster_bus_pkg::core_rsp_t [NUM_PORTS-1:0]    core_rsp_o,
  output logic [NUM_PORTS-1:0]                          core_rsp_valid_o,
  input  wire logic [NUM_PORTS-1:0]                     core_rsp_ready_i,
  output cluster_bus_pkg::cl_req_t                      cl_req_o,
  output logic                                          cl_req_valid_o,
  input  wire logic                                     cl_req_ready_i,
  input  cluster_bus_pkg::cl_rsp_t                      cl_rsp_i,
  input  wire logic                                     cl_rsp_valid_i,
  output logic                                          cl_rsp_ready_o
);

  localparam int PW  = cluster_bus_pkg::PortIdxWidth;
  localparam int CW  = cluster_bus_pkg::CoreIdWidth;
  localparam int CLW = cluster_bus_pkg::ClusterIdWidth;
  localparam logic [PW-1:0] LAST_PORT = PW'(NUM_PORTS - 1);

  logic [PW-1:0] prio_q;
  logic          lock_q;
  logic [PW-1:0] lock_idx_q;
  logic [PW-1:0] pick_idx;
  logic          pick_found;
  logic [PW-1:0] grant_idx;
  logic [PW-1:0] rsp_port;

  // Search starts at the port after the last grant
  always_comb begin
    int unsigned idx;
    pick_idx   = '0;
    pick_found = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      idx = (int'(prio_q) + i) % NUM_PORTS;
      if (!pick_found && core_req_valid_i[idx]) begin
        pick_found = 1'b1;
        pick_idx   = idx[PW-1:0];
      end
    end
  end

  assign grant_idx      = lock_q ? lock_idx_q : pick_idx;
  assign cl_req_valid_o = lock_q || pick_found;
  assign cl_req_o = '{op:    core_req_i[grant_idx].op,
                      addr:  core_req_i[grant_idx].addr,
                      wdata: core_req_i[grant_idx].wdata,
                      id:    {grant_idx, core_req_i[grant_idx].id}};

  // Grant stays locked until the downstream handshake
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (cl_req_valid_o) begin
      if (cl_req_ready_i) begin
        lock_q <= 1'b0;
        prio_q <= (grant_idx == LAST_PORT) ? '0 : grant_idx + 1'b1;
      end else begin
        lock_q     <= 1'b1;
        lock_idx_q <= grant_idx;
      end
    end
  end

  // ----------------------------------------
  // Response demux on the port tag
  // ----------------------------------------
  assign rsp_port = cl_rsp_i.id[CLW-1 -: PW];

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_port
    assign core_req_ready_o[i] = cl_req_ready_i && cl_req_valid_o && (grant_idx == PW'(i));
    assign core_rsp_o[i] = '{resp:  cl_rsp_i.resp,
                             rdata: cl_rsp_i.rdata,
                             id:    cl_rsp_i.id[CW-1:0]};
    assign core_rsp_valid_o[i] = cl_rsp_valid_i && (rsp_port == PW'(i));
  end

  always_comb begin
    cl_rsp_ready_o = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (rsp_port == PW'(i)) begin
        cl_rsp_ready_o = core_rsp_ready_i[i];
      end
    end
  end

endmodule

`default_nettype wire

/* src/bus_cut.sv */
// Request and response register slice
`timescale 1ns/100ps
`default_nettype none

module bus_cut (
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,
  input  cluster_bus_pkg::cl_req_t in_req_i,
  input  wire logic               in_req_valid_i,
  output logic                    in_req_ready_o,
  output cluster_bus_pkg::cl_req_t out_req_o,
  output logic                    out_req_valid_o,
  input  wire logic               out_req_ready_i,
  input  cluster_bus_pkg::cl_rsp_t out_rsp_i,
  input  wire logic               out_rsp_valid_i,
  output logic                    out_rsp_ready_o,
  output cluster_bus_pkg::cl_rsp_t in_rsp_o,
  output logic                    in_rsp_valid_o,
  input  wire logic               in_rsp_ready_i
);

  // Stage takes new data when empty or draining
  assign in_req_ready_o  = !out_req_valid_o || out_req_ready_i;
  assign out_rsp_ready_o = !in_rsp_valid_o || in_rsp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_req_valid_o <= 1'b0;
      in_rsp_valid_o  <= 1'b0;
    end else begin
      if (in_req_ready_o) begin
        out_req_valid_o <= in_req_valid_i;
      end
      if (out_rsp_ready_o) begin
        in_rsp_valid_o <= out_rsp_valid_i;
      end
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (in_req_valid_i && in_req_ready_o) begin
      out_req_o <= in_req_i;
    end
    if (out_rsp_valid_i && out_rsp_ready_o) begin
      in_rsp_o <= out_rsp_i;
    end
  end

endmodule

`default_nettype wire

/* src/id_remap.sv */
// Cluster to external ID remapper
`timescale 1ns/100ps
`default_nettype none

module id_remap #(
  parameter int REMAP_SLOTS = 4
) (
  input  wire logic                clk_i,
  input  wire logic                arst_n_i,
  input  cluster_bus_pkg::cl_req_t  cl_req_i,
  input  wire logic                cl_req_valid_i,
  output logic                     cl_req_ready_o,
  output cluster_bus_pkg::ext_req_t ext_req_o,
  output logic                     ext_req_valid_o,
  input  wire logic                ext_req_ready_i,
  input  cluster_bus_pkg::ext_rsp_t ext_rsp_i,
  input  wire logic                ext_rsp_valid_i,
  output logic                     ext_rsp_ready_o,
  output cluster_bus_pkg::cl_rsp_t  cl_rsp_o,
  output logic                     cl_rsp_valid_o,
  input  wire logic                cl_rsp_ready_i
);

  localparam int EW  = cluster_bus_pkg::ExtIdWidth;
  localparam int CLW = cluster_bus_pkg::ClusterIdWidth;

  logic [REMAP_SLOTS-1:0] busy_q;
  logic [CLW-1:0]         slot_id_q [REMAP_SLOTS];
  logic [EW-1:0]          free_idx;
  logic                   free_found;
  logic                   id_hit;
  logic                   stall;
  logic                   take;
  logic                   release_slot;

  // ----------------------------------------
  // Slot lookup
  // ----------------------------------------
  always_comb begin
    free_idx   = '0;
    free_found = 1'b0;
    id_hit     = 1'b0;
    for (int i = 0; i < REMAP_SLOTS; i++) begin
      if (!busy_q[i] && !free_found) begin
        free_found = 1'b1;
        free_idx   = i[EW-1:0];
      end
      if (busy_q[i] && slot_id_q[i] == cl_req_i.id) begin
        id_hit = 1'b1;
      end
    end
  end

  // One outstanding transaction per cluster ID
  assign stall           = !free_found || id_hit;
  assign ext_req_valid_o = cl_req_valid_i && !stall;
  assign cl_req_ready_o  = ext_req_ready_i && !stall;
  assign take            = ext_req_valid_o && ext_req_ready_i;

  assign ext_req_o = '{op:    cl_req_i.op,
                       addr:  cl_req_i.addr,
                       wdata: cl_req_i.wdata,
                       id:    free_idx};

  // Responses carry the slot number back
  assign cl_rsp_o = '{resp:  ext_rsp_i.resp,
                      rdata: ext_rsp_i.rdata,
                      id:    slot_id_q[ext_rsp_i.id]};
  assign cl_rsp_valid_o  = ext_rsp_valid_i;
  assign ext_rsp_ready_o = cl_rsp_ready_i;
  assign release_slot    = ext_rsp_valid_i && cl_rsp_ready_i;

  // ----------------------------------------
  // Slot table
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= '0;
    end else begin
      for (int i = 0; i < REMAP_SLOTS; i++) begin
        if (take && free_idx == i[EW-1:0]) begin
          busy_q[i] <= 1'b1;
        end else if (release_slot && ext_rsp_i.id == i[EW-1:0]) begin
          busy_q[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      slot_id_q[free_idx] <= cl_req_i.id;
    end
  end

endmodule

`default_nettype wire

/* cdc_src/cdc_src_fifo.sv */
// Gray pointer CDC source stage
`timescale 1ns/100ps
`default_nettype none

module cdc_src_fifo #(
  parameter int LOG_DEPTH = 1
) (
  input  wire logic                                       clk_i,
  input  wire logic                                       arst_n_i,
  input  cluster_bus_pkg::ext_req_t                       req_i,
  input  wire logic                                       req_valid_i,
  output logic                                            req_ready_o,
  output logic [LOG_DEPTH:0]                              req_wptr_o,
  output cluster_bus_pkg::ext_req_t [2**LOG_DEPTH-1:0]    req_data_o,
  input  wire logic [LOG_DEPTH:0]                         req_rptr_i,
  input  wire logic [LOG_DEPTH:0]                         rsp_wptr_i,
  input  cluster_bus_pkg::ext_rsp_t [2**LOG_DEPTH-1:0]    rsp_data_i,
  output cluster_bus_pkg::ext_rsp_t                       rsp_o,
  output logic                                            rsp_valid_o,
  input  wire logic                                       rsp_ready_i,
  output logic [LOG_DEPTH:0]                              rsp_rptr_o
);

  localparam logic [LOG_DEPTH:0] DEPTH_PTR = {1'b1, {LOG_DEPTH{1'b0}}};

  logic [LOG_DEPTH:0] wbin_q;
  logic [LOG_DEPTH:0] rptr_meta_q;
  logic [LOG_DEPTH:0] rptr_sync_q;
  logic [LOG_DEPTH:0] rbin_q;
  logic [LOG_DEPTH:0] wptr_meta_q;
  logic [LOG_DEPTH:0] wptr_sync_q;
  logic               push;
  logic               pop;

  function automatic logic [LOG_DEPTH:0] bin2gray(input logic [LOG_DEPTH:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [LOG_DEPTH:0] gray2bin(input logic [LOG_DEPTH:0] g);
    logic [LOG_DEPTH:0] b;
    b[LOG_DEPTH] = g[LOG_DEPTH];
    for (int i = LOG_DEPTH - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // ----------------------------------------
  // Request writer
  // ----------------------------------------
  // Full once every entry is still unread on the far side
  assign req_ready_o = (wbin_q - gray2bin(rptr_sync_q)) != DEPTH_PTR;
  assign push        = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wbin_q      <= '0;
      req_wptr_o  <= '0;
      rptr_meta_q <= '0;
      rptr_sync_q <= '0;
    end else begin
      rptr_meta_q <= req_rptr_i;
      rptr_sync_q <= rptr_meta_q;
      if (push) begin
        wbin_q     <= wbin_q + 1'b1;
        req_wptr_o <= bin2gray(wbin_q + 1'b1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      req_data_o[wbin_q[LOG_DEPTH-1:0]] <= req_i;
    end
  end

  // ----------------------------------------
  // Response reader
  // ----------------------------------------
  assign rsp_valid_o = rsp_rptr_o != wptr_sync_q;
  assign rsp_o       = rsp_data_i[rbin_q[LOG_DEPTH-1:0]];
  assign pop         = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rbin_q      <= '0;
      rsp_rptr_o  <= '0;
      wptr_meta_q <= '0;
      wptr_sync_q <= '0;
    end else begin
      wptr_meta_q <= rsp_wptr_i;
      wptr_sync_q <= wptr_meta_q;
      if (pop) begin
        rbin_q     <= rbin_q + 1'b1;
        rsp_rptr_o <= bin2gray(rbin_q + 1'b1);
      end
    end
  end

endmodule

`default_nettype wire

/* src/cluster_egress_top.sv */
// Cluster egress path top level
`timescale 1ns/100ps
`default_nettype none

module cluster_egress_top #(
  parameter int NUM_PORTS   = 2,
  parameter int REMAP_SLOTS = 4,
  parameter int LOG_DEPTH   = 1
) (
  input  wire logic                                    clk_i,
  input  wire logic                                    arst_n_i,
  input  cluster_bus_pkg::core_req_t [NUM_PORTS-1:0]   core_req_i,
  input  wire logic [NUM_PORTS-1:0]                    core_req_valid_i,
  output logic [NUM_PORTS-1:0]                         core_req_ready_o,
  output cluster_bus_pkg::core_rsp_t [NUM_PORTS-1:0]   core_rsp_o,
  output logic [NUM_PORTS-1:0]                         core_rsp_valid_o,
  input  wire logic [NUM_PORTS-1:0]                    core_rsp_ready_i,
  output logic [LOG_DEPTH:0]                           ext_req_wptr_o,
  output cluster_bus_pkg::ext_req_t [2**LOG_DEPTH-1:0] ext_req_data_o,
  input  wire logic [LOG_DEPTH:0]                      ext_req_rptr_i,
  input  wire logic [LOG_DEPTH:0]                      ext_rsp_wptr_i,
  input  cluster_bus_pkg::ext_rsp_t [2**LOG_DEPTH-1:0] ext_rsp_data_i,
  output logic [LOG_DEPTH:0]                           ext_rsp_rptr_o
);

  // Arbiter to cut
  cluster_bus_pkg::cl_req_t  arb_req;
  logic                      arb_req_valid;
  logic                      arb_req_ready;
  cluster_bus_pkg::cl_rsp_t  arb_rsp;
  logic                      arb_rsp_valid;
  logic                      arb_rsp_ready;

  // Cut to remapper
  cluster_bus_pkg::cl_req_t  cut_req;
  logic                      cut_req_valid;
  logic                      cut_req_ready;
  cluster_bus_pkg::cl_rsp_t  cut_rsp;
  logic                      cut_rsp_valid;
  logic                      cut_rsp_ready;

  // Remapper to CDC
  cluster_bus_pkg::ext_req_t ext_req;
  logic                      ext_req_valid;
  logic                      ext_req_ready;
  cluster_bus_pkg::ext_rsp_t ext_rsp;
  logic                      ext_rsp_valid;
  logic                      ext_rsp_ready;

  cluster_arbiter #(
    .NUM_PORTS (NUM_PORTS)
  ) cluster_arbiter_inst (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .core_req_i       (core_req_i),
    .core_req_valid_i (core_req_valid_i),
    .core_req_ready_o (core_req_ready_o),
    .core_rsp_o       (core_rsp_o),
    .core_rsp_valid_o (core_rsp_valid_o),
    .core_rsp_ready_i (core_rsp_ready_i),
    .cl_req_o         (arb_req),
    .cl_req_valid_o   (arb_req_valid),
    .cl_req_ready_i   (arb_req_ready),
    .cl_rsp_i         (arb_rsp),
    .cl_rsp_valid_i   (arb_rsp_valid),
    .cl_rsp_ready_o   (arb_rsp_ready)
  );

  bus_cut bus_cut_inst (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .in_req_i        (arb_req),
    .in_req_valid_i  (arb_req_valid),
    .in_req_ready_o  (arb_req_ready),
    .out_req_o       (cut_req),
    .out_req_valid_o (cut_req_valid),
    .out_req_ready_i (cut_req_ready),
    .out_rsp_i       (cut_rsp),
    .out_rsp_valid_i (cut_rsp_valid),
    .out_rsp_ready_o (cut_rsp_ready),
    .in_rsp_o        (arb_rsp),
    .in_rsp_valid_o  (arb_rsp_valid),
    .in_rsp_ready_i  (arb_rsp_ready)
  );

  id_remap #(
    .REMAP_SLOTS (REMAP_SLOTS)
  ) id_remap_inst (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .cl_req_i        (cut_req),
    .cl_req_valid_i  (cut_req_valid),
    .cl_req_ready_o  (cut_req_ready),
    .ext_req_o       (ext_req),
    .ext_req_valid_o (ext_req_valid),
    .ext_req_ready_i (ext_req_ready),
    .ext_rsp_i       (ext_rsp),
    .ext_rsp_valid_i (ext_rsp_valid),
    .ext_rsp_ready_o (ext_rsp_ready),
    .cl_rsp_o        (cut_rsp),
    .cl_rsp_valid_o  (cut_rsp_valid),
    .cl_rsp_ready_i  (cut_rsp_ready)
  );

  cdc_src_fifo #(
    .LOG_DEPTH (LOG_DEPTH)
  ) cdc_src_fifo_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (ext_req),
    .req_valid_i (ext_req_valid),
    .req_ready_o (ext_req_ready),
    .req_wptr_o  (ext_req_wptr_o),
    .req_data_o  (ext_req_data_o),
    .req_rptr_i  (ext_req_rptr_i),
    .rsp_wptr_i  (ext_rsp_wptr_i),
    .rsp_data_i  (ext_rsp_data_i),
    .rsp_o       (ext_rsp),
    .rsp_valid_o (ext_rsp_valid),
    .rsp_ready_i (ext_rsp_ready),
    .rsp_rptr_o  (ext_rsp_rptr_o)
  );

endmodule

`default_nettype wire

/* test/cluster_egress_asserts.sv */
// Egress protocol assertions
`timescale 1ns/100ps
`default_nettype none

module cluster_egress_asserts #(
  parameter int NUM_PORTS = 2,
  parameter int LOG_DEPTH = 1
) (
  input wire logic                                  clk_i,
  input wire logic                                  arst_n_i,
  input cluster_bus_pkg::core_rsp_t [NUM_PORTS-1:0] core_rsp_o,
  input wire logic [NUM_PORTS-1:0]                  core_rsp_valid_o,
  input wire logic [NUM_PORTS-1:0]                  core_rsp_ready_i,
  input wire logic [LOG_DEPTH:0]                    ext_req_wptr_o,
  input wire logic [LOG_DEPTH:0]                    ext_rsp_rptr_o
);

  // Gray pointers move by one bit at most
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $countones(ext_req_wptr_o ^ $past(ext_req_wptr_o)) <= 1)
    else $error("request write pointer changed more than one bit");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $countones(ext_rsp_rptr_o ^ $past(ext_rsp_rptr_o)) <= 1)
    else $error("response read pointer changed more than one bit");

  assert property (@(posedge clk_i) !arst_n_i |-> (ext_req_wptr_o == '0 && ext_rsp_rptr_o == '0))
    else $error("pointers not zero during reset");

  // ----------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_rsp_hold
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      core_rsp_valid_o[p] && !core_rsp_ready_i[p] |=>
        core_rsp_valid_o[p] && $stable(core_rsp_o[p]))
      else $error("response dropped or changed before ready");
  end

endmodule

bind cluster_egress_top cluster_egress_asserts #(
  .NUM_PORTS (NUM_PORTS),
  .LOG_DEPTH (LOG_DEPTH)
) cluster_egress_asserts_inst (
  .clk_i            (clk_i),
  .arst_n_i         (arst_n_i),
  .core_rsp_o       (core_rsp_o),
  .core_rsp_valid_o (core_rsp_valid_o),
  .core_rsp_ready_i (core_rsp_ready_i),
  .ext_req_wptr_o   (ext_req_wptr_o),
  .ext_rsp_rptr_o   (ext_rsp_rptr_o)
);

`default_nettype wire

/* test/tb_cluster_egress.sv */
// Cluster egress testbench
`timescale 1ns/100ps
`default_nettype none

module tb_cluster_egress;

  localparam int NUM_PORTS   = 2;
  localparam int REMAP_SLOTS = 4;
  localparam int LOG_DEPTH   = 1;
  localparam int DEPTH       = 2**LOG_DEPTH;
  localparam int CLK_PERIOD  = 100;
  localparam int NUM_TXN     = 30;

  logic clk_i;
  logic arst_n_i;
  cluster_bus_pkg::core_req_t [NUM_PORTS-1:0] core_req;
  logic [NUM_PORTS-1:0]                       core_req_valid;
  logic [NUM_PORTS-1:0]                       core_req_ready;
  cluster_bus_pkg::core_rsp_t [NUM_PORTS-1:0] core_rsp;
  logic [NUM_PORTS-1:0]                       core_rsp_valid;
  logic [NUM_PORTS-1:0]                       core_rsp_ready;
  logic [LOG_DEPTH:0]                         req_wptr;
  cluster_bus_pkg::ext_req_t [DEPTH-1:0]      req_data;
  logic [LOG_DEPTH:0]                         req_rptr;
  logic [LOG_DEPTH:0]                         rsp_wptr;
  cluster_bus_pkg::ext_rsp_t [DEPTH-1:0]      rsp_data;
  logic [LOG_DEPTH:0]                         rsp_rptr;

  // Destination model state
  logic [LOG_DEPTH:0]        dst_rbin;
  logic [LOG_DEPTH:0]        dst_wbin;
  logic                      hold_req;
  logic                      hold_rsp;
  int                        dst_req_cnt;
  logic [31:0]               mem [logic [31:0]];
  cluster_bus_pkg::ext_rsp_t pend_q [$];
  cluster_bus_pkg::core_rsp_t rx0_q [$];
  cluster_bus_pkg::core_rsp_t rx1_q [$];
  int                        skip_cnt [NUM_PORTS];

  cluster_egress_top #(
    .NUM_PORTS   (NUM_PORTS),
    .REMAP_SLOTS (REMAP_SLOTS),
    .LOG_DEPTH   (LOG_DEPTH)
  ) cluster_egress_top_inst (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .core_req_i       (core_req),
    .core_req_valid_i (core_req_valid),
    .core_req_ready_o (core_req_ready),
    .core_rsp_o       (core_rsp),
    .core_rsp_valid_o (core_rsp_valid),
    .core_rsp_ready_i (core_rsp_ready),
    .ext_req_wptr_o   (req_wptr),
    .ext_req_data_o   (req_data),
    .ext_req_rptr_i   (req_rptr),
    .ext_rsp_wptr_i   (rsp_wptr),
    .ext_rsp_data_i   (rsp_data),
    .ext_rsp_rptr_o   (rsp_rptr)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [LOG_DEPTH:0] to_gray(input logic [LOG_DEPTH:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [LOG_DEPTH:0] from_gray(input logic [LOG_DEPTH:0] g);
    logic [LOG_DEPTH:0] b;
    b = '0;
    for (int i = LOG_DEPTH; i >= 0; i--) begin
      b[i] = g[i] ^ ((i == LOG_DEPTH) ? 1'b0 : b[i+1]);
    end
    return b;
  endfunction

  // Unwritten memory words
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return a ^ 32'hA5C3_0F69;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #10;
  endtask

  // ----------------------------------------
  // Destination side of the CDC FIFO
  // ----------------------------------------
  always @(posedge clk_i) begin
    cluster_bus_pkg::ext_req_t req;
    cluster_bus_pkg::ext_rsp_t rsp;
    #10;
    if (arst_n_i) begin
      if (!hold_req && to_gray(dst_rbin) != req_wptr) begin
        req        = req_data[dst_rbin[LOG_DEPTH-1:0]];
        rsp.id     = req.id;
        rsp.rdata  = '0;
        rsp.resp   = cluster_bus_pkg::RESP_OKAY;
        if (req.addr[31]) begin
          rsp.resp = cluster_bus_pkg::RESP_ERR;
        end else if (req.op == cluster_bus_pkg::OP_WRITE) begin
          mem[req.addr] = req.wdata;
        end else begin
          rsp.rdata = mem.exists(req.addr) ? mem[req.addr] : fill_word(req.addr);
        end
        pend_q.push_back(rsp);
        dst_rbin    = dst_rbin + 1'b1;
        req_rptr    = to_gray(dst_rbin);
        dst_req_cnt = dst_req_cnt + 1;
      end
      if (!hold_rsp && pend_q.size() > 0 &&
          (dst_wbin - from_gray(rsp_rptr)) != (LOG_DEPTH+1)'(DEPTH)) begin
        rsp_data[dst_wbin[LOG_DEPTH-1:0]] = pend_q.pop_front();
        dst_wbin = dst_wbin + 1'b1;
        rsp_wptr = to_gray(dst_wbin);
      end
    end
  end

  // Response capture and grant fairness, sampled mid cycle
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (core_rsp_valid[0] && core_rsp_ready[0]) rx0_q.push_back(core_rsp[0]);
      if (core_rsp_valid[1] && core_rsp_ready[1]) rx1_q.push_back(core_rsp[1]);
      for (int g = 0; g < NUM_PORTS; g++) begin
        if (core_req_valid[g] && core_req_ready[g]) begin
          skip_cnt[g] = 0;
          if (core_req_valid[1-g]) begin
            skip_cnt[1-g] = skip_cnt[1-g] + 1;
            check("grants_while_waiting", 64'(skip_cnt[1-g]) <= 64'd1 ? 64'd1 : 64'd0, 64'd1);
          end
        end
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (!core_req_valid[p]) skip_cnt[p] = 0;
      end
    end
  end

  task automatic send_req(input int p, input cluster_bus_pkg::bus_op_e op,
                          input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] id);
    core_req[p]       = '{op: op, addr: addr, wdata: data, id: id};
    core_req_valid[p] = 1'b1;
    @(negedge clk_i);
    while (!core_req_ready[p]) @(negedge clk_i);
    @(posedge clk_i);
    #10;
    core_req_valid[p] = 1'b0;
  endtask

  task automatic wait_rsp(input int p, input int n);
    int cnt;
    cnt = 0;
    while (((p == 0) ? rx0_q.size() : rx1_q.size()) < n) begin
      wait_cycles(1);
      cnt++;
      if (cnt > 300) begin
        $display("timeout: port %0d did not receive %0d responses", p, n);
        $display("SIMULATION FAILED");
        $fatal(1);
      end
    end
  endtask

  task automatic take_rsp(input int p, input cluster_bus_pkg::bus_resp_e resp,
                          input logic [31:0] rdata, input logic [3:0] id);
    cluster_bus_pkg::core_rsp_t r;
    r = (p == 0) ? rx0_q.pop_front() : rx1_q.pop_front();
    check($sformatf("core_rsp_o[%0d].resp", p), 64'(r.resp), 64'(resp));
    check($sformatf("core_rsp_o[%0d].rdata", p), 64'(r.rdata), 64'(rdata));
    check($sformatf("core_rsp_o[%0d].id", p), 64'(r.id), 64'(id));
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset();
    check("ext_req_wptr_o", 64'(req_wptr), 64'd0);
    check("ext_rsp_rptr_o", 64'(rsp_rptr), 64'd0);
    check("core_rsp_valid_o", 64'(core_rsp_valid), 64'd0);
  endtask

  task automatic test_write_read();
    logic [31:0] d;
    d = $urandom;
    send_req(0, cluster_bus_pkg::OP_WRITE, 32'h0000_0100, d, 4'd3);
    wait_rsp(0, 1);
    take_rsp(0, cluster_bus_pkg::RESP_OKAY, 32'd0, 4'd3);
    send_req(0, cluster_bus_pkg::OP_READ, 32'h0000_0100, 32'd0, 4'd4);
    wait_rsp(0, 1);
    take_rsp(0, cluster_bus_pkg::RESP_OKAY, d, 4'd4);
  endtask

  task automatic test_two_ports();
    logic [31:0] d [2][3];
    logic [31:0] a [2][3];
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < 3; i++) begin
        d[p][i] = $urandom;
        a[p][i] = {1'b0, 18'($urandom), 3'(p), 2'(i), 8'h00};
      end
    end
    fork
      for (int i = 0; i < 3; i++) begin
        send_req(0, cluster_bus_pkg::OP_WRITE, a[0][i], d[0][i], 4'(i + 1));
      end
      for (int i = 0; i < 3; i++) begin
        send_req(1, cluster_bus_pkg::OP_WRITE, a[1][i], d[1][i], 4'(i + 1));
      end
    join
    fork
      for (int i = 0; i < 3; i++) send_req(0, cluster_bus_pkg::OP_READ, a[0][i], 32'd0, 4'(i + 4));
      for (int i = 0; i < 3; i++) send_req(1, cluster_bus_pkg::OP_READ, a[1][i], 32'd0, 4'(i + 4));
    join
    for (int p = 0; p < 2; p++) begin
      wait_rsp(p, 6);
      for (int i = 0; i < 3; i++) take_rsp(p, cluster_bus_pkg::RESP_OKAY, 32'd0, 4'(i + 1));
      for (int i = 0; i < 3; i++) take_rsp(p, cluster_bus_pkg::RESP_OKAY, d[p][i], 4'(i + 4));
    end
  endtask

  task automatic test_error_resp();
    core_rsp_ready[1] = 1'b0;
    send_req(1, cluster_bus_pkg::OP_READ, 32'h8000_0010, 32'd0, 4'd7);
    send_req(1, cluster_bus_pkg::OP_READ, 32'h8000_0020, 32'd0, 4'd8);
    wait_cycles(10);
    // First response parks in the cut, the second waits in the CDC reader
    check("core_rsp_valid_o", 64'(core_rsp_valid), 64'b10);
    check("port 1 response count", 64'(rx1_q.size()), 64'd0);
    check("ext_rsp_rptr_o", 64'(rsp_rptr), 64'(to_gray(dst_wbin - 1'b1)));
    core_rsp_ready[1] = 1'b1;
    wait_rsp(1, 2);
    take_rsp(1, cluster_bus_pkg::RESP_ERR, 32'd0, 4'd7);
    take_rsp(1, cluster_bus_pkg::RESP_ERR, 32'd0, 4'd8);
    wait_cycles(10);
    check("port 0 response count", 64'(rx0_q.size()), 64'd0);
  endtask

  task automatic test_cdc_backpressure();
    logic [LOG_DEPTH:0] start;
    start    = from_gray(req_wptr);
    hold_req = 1'b1;
    fork
      for (int i = 0; i < 3; i++) begin
        send_req(0, cluster_bus_pkg::OP_WRITE, 32'h200 + 32'(i), 32'd0, 4'(i + 1));
      end
      for (int i = 0; i < 3; i++) begin
        send_req(1, cluster_bus_pkg::OP_WRITE, 32'h300 + 32'(i), 32'd0, 4'(i + 1));
      end
    join_none
    wait_cycles(20);
    check("ext_req_wptr_o", 64'(req_wptr), 64'(to_gray(start + (LOG_DEPTH+1)'(DEPTH))));
    @(negedge clk_i);
    check("core_req_ready_o", 64'(core_req_ready), 64'd0);
    wait_cycles(1);
    hold_req = 1'b0;
    for (int p = 0; p < 2; p++) begin
      wait_rsp(p, 3);
      for (int i = 0; i < 3; i++) take_rsp(p, cluster_bus_pkg::RESP_OKAY, 32'd0, 4'(i + 1));
    end
  endtask

  task automatic test_remap_limits();
    int base;
    hold_rsp = 1'b1;
    base     = dst_req_cnt;
    fork
      for (int i = 0; i < 3; i++) begin
        send_req(0, cluster_bus_pkg::OP_WRITE, 32'h400 + 32'(i), 32'd0, 4'(i + 1));
      end
      for (int i = 0; i < 3; i++) begin
        send_req(1, cluster_bus_pkg::OP_WRITE, 32'h500 + 32'(i), 32'd0, 4'(i + 1));
      end
    join_none
    wait_cycles(20);
    check("requests at destination", 64'(dst_req_cnt - base), 64'(REMAP_SLOTS));
    hold_rsp = 1'b0;
    for (int p = 0; p < 2; p++) begin
      wait_rsp(p, 3);
      for (int i = 0; i < 3; i++) take_rsp(p, cluster_bus_pkg::RESP_OKAY, 32'd0, 4'(i + 1));
    end
    // Same cluster ID twice
    hold_rsp = 1'b1;
    base     = dst_req_cnt;
    send_req(0, cluster_bus_pkg::OP_WRITE, 32'h600, 32'd0, 4'd9);
    fork
      send_req(0, cluster_bus_pkg::OP_WRITE, 32'h604, 32'd0, 4'd9);
    join_none
    wait_cycles(20);
    check("requests at destination", 64'(dst_req_cnt - base), 64'd1);
    hold_rsp = 1'b0;
    wait_rsp(0, 2);
    take_rsp(0, cluster_bus_pkg::RESP_OKAY, 32'd0, 4'd9);
    take_rsp(0, cluster_bus_pkg::RESP_OKAY, 32'd0, 4'd9);
    check("requests at destination", 64'(dst_req_cnt - base), 64'd2);
  endtask

  initial begin
    #(NUM_TXN * 50 * CLK_PERIOD);
    $display("timeout: tests did not finish in time");
    $display("SIMULATION FAILED");
    $fatal(1);
  end

  initial begin
    int seed;
    seed           = $urandom(55330);
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    core_req       = '0;
    core_req_valid = '0;
    core_rsp_ready = '1;
    req_rptr       = '0;
    rsp_wptr       = '0;
    rsp_data       = '0;
    dst_rbin       = '0;
    dst_wbin       = '0;
    hold_req       = 1'b0;
    hold_rsp       = 1'b0;
    dst_req_cnt    = 0;
    skip_cnt       = '{default: 0};
    wait_cycles(5);
    test_reset();
    arst_n_i = 1'b1;
    wait_cycles(2);
    test_reset();
    test_write_read();
    test_two_ports();
    test_error_resp();
    test_cdc_backpressure();
    test_remap_limits();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
common/cluster_bus_pkg.sv
src/cluster_arbiter.sv
src/bus_cut.sv
src/id_remap.sv
cdc_src/cdc_src_fifo.sv
src/cluster_egress_top.sv
test/cluster_egress_asserts.sv
test/tb_cluster_egress.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_cluster_egress
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
